// ==== hw/vdp_pkg.sv ====
`default_nettype none

package vdp_pkg;

  localparam int data_w = 64;
  localparam int addr_w = 32;

  typedef logic [data_w-1:0] vdp_data_t;
  typedef logic [addr_w-1:0] vdp_addr_t;
  typedef logic [7:0]        vdp_len_t;
  typedef logic [7:0]        csr_addr_t;

  // register offsets as seen by the host.
  localparam csr_addr_t csr_a_ptr   = 8'h00;
  localparam csr_addr_t csr_b_ptr   = 8'h08;
  localparam csr_addr_t csr_len     = 8'h10;
  localparam csr_addr_t csr_start   = 8'h18;
  localparam csr_addr_t csr_status  = 8'h20;
  localparam csr_addr_t csr_res_ptr = 8'h28;
  localparam csr_addr_t csr_result  = 8'h30;

  localparam int elem_bytes = 8;

  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

  typedef struct packed {
    logic      write;
    csr_addr_t addr;
    vdp_data_t wdata;
  } csr_cmd_t;

  typedef struct packed {
    logic      write;
    vdp_addr_t addr;
    vdp_data_t wdata;
  } mem_req_t;

  typedef struct packed {
    vdp_addr_t a_ptr;
    vdp_addr_t b_ptr;
    vdp_addr_t res_ptr;
    vdp_len_t  len;
  } vdp_cfg_t;

  typedef struct packed {
    vdp_data_t a;
    vdp_data_t b;
    logic      last;
  } pair_t;

  typedef struct packed {
    vdp_data_t prod;
    logic      last;
  } prod_t;

  typedef enum logic [2:0] {
    fetch_idle,
    fetch_rd_a,
    fetch_rd_b,
    fetch_push,
    fetch_wr_res,
    fetch_wait_wr
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== hw/vdp_csr.sv ====
`default_nettype none

module vdp_csr import vdp_pkg::*; (
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        csr_cmd_valid_i,
  input  csr_cmd_t   csr_cmd_i,
  input  wire        done_i,
  input  vdp_data_t  result_i,
  output logic       csr_resp_valid_o,
  output vdp_data_t  csr_resp_data_o,
  output vdp_cfg_t   cfg_o,
  output logic       start_o
);

  vdp_addr_t a_ptr_r;
  vdp_addr_t b_ptr_r;
  vdp_addr_t res_ptr_r;
  vdp_len_t  len_r;
  vdp_data_t result_r;
  logic      busy_r;
  logic      done_r;
  logic      wr_en;
  logic      rd_en;
  logic      start_req;
  vdp_data_t status;
  vdp_data_t rd_data;

  assign wr_en = csr_cmd_valid_i && csr_cmd_i.write;
  assign rd_en = csr_cmd_valid_i && !csr_cmd_i.write;

  // a start while a run is active is dropped.
  assign start_req = wr_en && (csr_cmd_i.addr == csr_start) && (|csr_cmd_i.wdata) && !busy_r;

  always_comb begin
    status = '0;
    status[status_busy_bit] = busy_r;
    status[status_done_bit] = done_r;
  end

  always_comb begin
    case (csr_cmd_i.addr)
      csr_a_ptr:   rd_data = vdp_data_t'(a_ptr_r);
      csr_b_ptr:   rd_data = vdp_data_t'(b_ptr_r);
      csr_len:     rd_data = vdp_data_t'(len_r);
      csr_status:  rd_data = status;
      csr_res_ptr: rd_data = vdp_data_t'(res_ptr_r);
      csr_result:  rd_data = result_r;
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      res_ptr_r <= '0;
      len_r     <= '0;
    end else if (wr_en) begin
      case (csr_cmd_i.addr)
        csr_a_ptr:   a_ptr_r   <= vdp_addr_t'(csr_cmd_i.wdata);
        csr_b_ptr:   b_ptr_r   <= vdp_addr_t'(csr_cmd_i.wdata);
        csr_len:     len_r     <= vdp_len_t'(csr_cmd_i.wdata);
        csr_res_ptr: res_ptr_r <= vdp_addr_t'(csr_cmd_i.wdata);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      start_o <= 1'b0;
      busy_r  <= 1'b0;
      done_r  <= 1'b0;
    end else begin
      start_o <= start_req;
      if (start_req) begin
        busy_r <= 1'b1;
        done_r <= 1'b0;
      end else if (done_i) begin
        busy_r <= 1'b0;
        done_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_r <= '0;
    end else if (done_i) begin
      result_r <= result_i;
    end
  end

  // every command gets its response one cycle later; writes answer zero.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      csr_resp_valid_o <= 1'b0;
    end else begin
      csr_resp_valid_o <= csr_cmd_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    csr_resp_data_o <= rd_en ? rd_data : '0;
  end

  assign cfg_o.a_ptr   = a_ptr_r;
  assign cfg_o.b_ptr   = b_ptr_r;
  assign cfg_o.res_ptr = res_ptr_r;
  assign cfg_o.len     = len_r;

endmodule

`default_nettype wire

// ==== hw/vdp_fetch.sv ====
`default_nettype none

module vdp_fetch import vdp_pkg::*; (
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        start_i,
  input  vdp_cfg_t   cfg_i,
  input  wire        mem_req_ready_i,
  input  wire        mem_resp_valid_i,
  input  vdp_data_t  mem_resp_data_i,
  input  wire        pair_ready_i,
  input  wire        sum_valid_i,
  input  vdp_data_t  sum_i,
  output logic       mem_req_valid_o,
  output mem_req_t   mem_req_o,
  output logic       pair_valid_o,
  output pair_t      pair_o,
  output logic       done_o
);

  fetch_state_e state_r;
  vdp_cfg_t     cfg_r;
  vdp_len_t     idx_r;
  logic         sent_r;
  vdp_data_t    a_r;
  vdp_data_t    b_r;
  vdp_data_t    res_r;
  vdp_addr_t    offset;
  logic         last_elem;
  logic         req_phase;
  logic         req_fire;
  logic         resp_fire;

  assign offset    = vdp_addr_t'(idx_r) * vdp_addr_t'(elem_bytes);
  assign last_elem = (idx_r == cfg_r.len - vdp_len_t'(1));

  // sent_r marks the single request as accepted and awaiting its response.
  assign req_phase = (state_r == fetch_rd_a) || (state_r == fetch_rd_b) ||
                     (state_r == fetch_wait_wr);
  assign mem_req_valid_o = req_phase && !sent_r;
  assign req_fire  = mem_req_valid_o && mem_req_ready_i;
  assign resp_fire = req_phase && sent_r && mem_resp_valid_i;

  always_comb begin
    mem_req_o.write = (state_r == fetch_wait_wr);
    mem_req_o.wdata = res_r;
    case (state_r)
      fetch_rd_a: mem_req_o.addr = cfg_r.a_ptr + offset;
      fetch_rd_b: mem_req_o.addr = cfg_r.b_ptr + offset;
      default:    mem_req_o.addr = cfg_r.res_ptr;
    endcase
  end

  assign pair_valid_o = (state_r == fetch_push);
  assign pair_o.a     = a_r;
  assign pair_o.b     = b_r;
  assign pair_o.last  = last_elem;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= fetch_idle;
      sent_r  <= 1'b0;
      idx_r   <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (req_fire) begin
        sent_r <= 1'b1;
      end else if (resp_fire) begin
        sent_r <= 1'b0;
      end
      case (state_r)
        fetch_idle: begin
          idx_r <= '0;
          if (start_i) begin
            // an empty vector skips the stages and stores a zero sum.
            state_r <= (cfg_i.len == '0) ? fetch_wait_wr : fetch_rd_a;
          end
        end
        fetch_rd_a: begin
          if (resp_fire) begin
            state_r <= fetch_rd_b;
          end
        end
        fetch_rd_b: begin
          if (resp_fire) begin
            state_r <= fetch_push;
          end
        end
        fetch_push: begin
          if (pair_ready_i) begin
            idx_r   <= idx_r + vdp_len_t'(1);
            state_r <= last_elem ? fetch_wr_res : fetch_rd_a;
          end
        end
        fetch_wr_res: begin
          if (sum_valid_i) begin
            state_r <= fetch_wait_wr;
          end
        end
        fetch_wait_wr: begin
          if (resp_fire) begin
            done_o  <= 1'b1;
            state_r <= fetch_idle;
          end
        end
        default: state_r <= fetch_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == fetch_idle && start_i) begin
      cfg_r <= cfg_i;
      res_r <= '0;
    end
    if (state_r == fetch_wr_res && sum_valid_i) begin
      res_r <= sum_i;
    end
    if (state_r == fetch_rd_a && resp_fire) begin
      a_r <= mem_resp_data_i;
    end
    if (state_r == fetch_rd_b && resp_fire) begin
      b_r <= mem_resp_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vdp_mul_stage.sv ====
`default_nettype none

module vdp_mul_stage import vdp_pkg::*; (
  input  wire    clk_i,
  input  wire    reset_i,
  input  wire    pair_valid_i,
  input  pair_t  pair_i,
  input  wire    prod_ready_i,
  output logic   pair_ready_o,
  output logic   prod_valid_o,
  output prod_t  prod_o
);

  logic accept;

  // the output register takes a new pair when empty or drained this cycle.
  assign pair_ready_o = !prod_valid_o || prod_ready_i;
  assign accept       = pair_valid_i && pair_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prod_valid_o <= 1'b0;
    end else if (accept) begin
      prod_valid_o <= 1'b1;
    end else if (prod_ready_i) begin
      prod_valid_o <= 1'b0;
    end
  end

  // only the low 64 bits of the product are kept.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      prod_o.prod <= pair_i.a * pair_i.b;
      prod_o.last <= pair_i.last;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vdp_accum_stage.sv ====
`default_nettype none

module vdp_accum_stage import vdp_pkg::*; (
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        prod_valid_i,
  input  prod_t      prod_i,
  output logic       prod_ready_o,
  output logic       sum_valid_o,
  output vdp_data_t  sum_o
);

  vdp_data_t acc_r;
  vdp_data_t acc_next;

  // one add per cycle, so back-pressure is never needed.
  assign prod_ready_o = 1'b1;
  assign acc_next     = acc_r + prod_i.prod;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_r       <= '0;
      sum_valid_o <= 1'b0;
    end else begin
      sum_valid_o <= 1'b0;
      if (prod_valid_i) begin
        if (prod_i.last) begin
          // clear for the next run as the total leaves.
          acc_r       <= '0;
          sum_valid_o <= 1'b1;
        end else begin
          acc_r <= acc_next;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (prod_valid_i && prod_i.last) begin
      sum_o <= acc_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vdp_top.sv ====
`default_nettype none

module vdp_top import vdp_pkg::*; (
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        csr_cmd_valid_i,
  input  csr_cmd_t   csr_cmd_i,
  output logic       csr_resp_valid_o,
  output vdp_data_t  csr_resp_data_o,
  output logic       mem_req_valid_o,
  output mem_req_t   mem_req_o,
  input  wire        mem_req_ready_i,
  input  wire        mem_resp_valid_i,
  input  vdp_data_t  mem_resp_data_i,
  output logic       done_o
);

  vdp_cfg_t  cfg;
  logic      start;
  logic      pair_valid;
  logic      pair_ready;
  pair_t     pair;
  logic      prod_valid;
  logic      prod_ready;
  prod_t     prod;
  logic      sum_valid;
  vdp_data_t sum;

  // the write data of the last request still holds the stored sum at the done pulse.
  vdp_csr u_csr (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .csr_cmd_valid_i  (csr_cmd_valid_i),
    .csr_cmd_i        (csr_cmd_i),
    .done_i           (done_o),
    .result_i         (mem_req_o.wdata),
    .csr_resp_valid_o (csr_resp_valid_o),
    .csr_resp_data_o  (csr_resp_data_o),
    .cfg_o            (cfg),
    .start_o          (start)
  );

  vdp_fetch u_fetch (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .start_i          (start),
    .cfg_i            (cfg),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .pair_ready_i     (pair_ready),
    .sum_valid_i      (sum_valid),
    .sum_i            (sum),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .pair_valid_o     (pair_valid),
    .pair_o           (pair),
    .done_o           (done_o)
  );

  vdp_mul_stage u_mul (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .pair_valid_i (pair_valid),
    .pair_i       (pair),
    .prod_ready_i (prod_ready),
    .pair_ready_o (pair_ready),
    .prod_valid_o (prod_valid),
    .prod_o       (prod)
  );

  vdp_accum_stage u_accum (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .prod_valid_i (prod_valid),
    .prod_i       (prod),
    .prod_ready_o (prod_ready),
    .sum_valid_o  (sum_valid),
    .sum_o        (sum)
  );

endmodule

`default_nettype wire

// ==== tb/vdp_mem_model.sv ====
`default_nettype none

module vdp_mem_model import vdp_pkg::*; (
  input  wire           clk_i,
  input  wire           reset_i,
  input  wire           stall_i,
  input  wire           req_valid_i,
  input  wire mem_req_t req_i,
  output logic          req_ready_o,
  output logic          resp_valid_o,
  output vdp_data_t     resp_data_o
);

  vdp_data_t   mem [logic [28:0]];
  vdp_data_t   data_q [$];
  int unsigned due_q [$];
  int unsigned cycle_cnt;
  int unsigned lat;
  logic        ready;
  vdp_data_t   rdata;

  task automatic write_word(input vdp_addr_t addr, input vdp_data_t data);
    mem[addr[31:3]] = data;
  endtask

  // untouched words return a pattern built from their address.
  function automatic vdp_data_t read_word(input vdp_addr_t addr);
    if (mem.exists(addr[31:3])) begin
      return mem[addr[31:3]];
    end
    return {~addr, addr};
  endfunction

  initial begin
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_data_o  = '0;
    cycle_cnt    = 0;
  end

  // all outputs change on the falling edge; a request seen here is taken at the next rising edge.
  always @(negedge clk_i) begin
    if (reset_i) begin
      data_q.delete();
      due_q.delete();
      req_ready_o  <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      cycle_cnt = cycle_cnt + 1;
      resp_valid_o <= 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
        resp_valid_o <= 1'b1;
        resp_data_o  <= data_q.pop_front();
        void'(due_q.pop_front());
      end
      ready = stall_i ? (($urandom % 3) != 0) : 1'b1;
      req_ready_o <= ready;
      if (req_valid_i && ready) begin
        if (req_i.write) begin
          write_word(req_i.addr, req_i.wdata);
          rdata = '0;
        end else begin
          rdata = read_word(req_i.addr);
        end
        lat = stall_i ? 1 + ($urandom % 5) : 1;
        data_q.push_back(rdata);
        due_q.push_back(cycle_cnt + lat);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/vdp_checker.sv ====
`default_nettype none

module vdp_checker import vdp_pkg::*; (
  input wire           clk_i,
  input wire           reset_i,
  input wire           mem_req_valid_o,
  input wire mem_req_t mem_req_o,
  input wire           mem_req_ready_i,
  input wire           mem_resp_valid_i,
  input wire           done_o
);

  int   fail_cnt = 0;
  logic outstanding_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= 1'b0;
    end else if (mem_req_valid_o && mem_req_ready_i) begin
      outstanding_r <= 1'b1;
    end else if (mem_resp_valid_i) begin
      outstanding_r <= 1'b0;
    end
  end

  req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else begin
      $error("memory request changed before it was accepted");
      fail_cnt++;
    end

  done_single: assert property (@(posedge clk_i) disable iff (reset_i)
    done_o |=> !done_o)
    else begin
      $error("done_o stayed high for two cycles");
      fail_cnt++;
    end

  one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o && mem_req_ready_i |-> !outstanding_r)
    else begin
      $error("second memory request issued before the response");
      fail_cnt++;
    end

endmodule

bind vdp_top vdp_checker u_checker (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .mem_req_valid_o  (mem_req_valid_o),
  .mem_req_o        (mem_req_o),
  .mem_req_ready_i  (mem_req_ready_i),
  .mem_resp_valid_i (mem_resp_valid_i),
  .done_o           (done_o)
);

`default_nettype wire

// ==== tb/vdp_tb.sv ====
`default_nettype none

module vdp_tb import vdp_pkg::*; ();

  typedef struct packed {
    vdp_len_t  len;
    vdp_addr_t a_ptr;
    vdp_addr_t b_ptr;
    vdp_addr_t res_ptr;
    logic      stall;
  } run_row_t;

  // a row with stall set runs again back to back under random memory timing.
  run_row_t rows [0:3] = '{
    '{8'd1,   32'h0000_1000, 32'h0000_2000, 32'h0000_3000, 1'b0},
    '{8'd8,   32'h0000_4000, 32'h0000_5000, 32'h0000_3008, 1'b1},
    '{8'd255, 32'h0001_0000, 32'h0002_0000, 32'h0000_3010, 1'b1},
    '{8'd0,   32'h0000_6000, 32'h0000_7000, 32'h0000_3018, 1'b1}
  };

  localparam int run_limit = 20000;

  logic      clk = 1'b0;
  logic      reset;
  logic      stall;
  logic      cmd_valid;
  csr_cmd_t  cmd;
  logic      resp_valid;
  vdp_data_t resp_data;
  logic      req_valid;
  mem_req_t  req;
  logic      req_ready;
  logic      mem_resp_valid;
  vdp_data_t mem_resp_data;
  logic      done;
  int        done_cnt = 0;
  int        err_cnt = 0;
  int        tests_run = 0;
  int        tests_failed = 0;

  always #4 clk = ~clk;

  vdp_top u_dut (
    .clk_i            (clk),
    .reset_i          (reset),
    .csr_cmd_valid_i  (cmd_valid),
    .csr_cmd_i        (cmd),
    .csr_resp_valid_o (resp_valid),
    .csr_resp_data_o  (resp_data),
    .mem_req_valid_o  (req_valid),
    .mem_req_o        (req),
    .mem_req_ready_i  (req_ready),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_data_i  (mem_resp_data),
    .done_o           (done)
  );

  vdp_mem_model u_mem (
    .clk_i        (clk),
    .reset_i      (reset),
    .stall_i      (stall),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .resp_valid_o (mem_resp_valid),
    .resp_data_o  (mem_resp_data)
  );

  always @(posedge clk) begin
    if (reset) begin
      done_cnt <= 0;
    end else if (done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  task automatic compare(input string name, input vdp_data_t got, input vdp_data_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic csr_access(input logic write, input csr_addr_t addr, input vdp_data_t wdata,
                            output vdp_data_t rdata);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd.write = write;
    cmd.addr  = addr;
    cmd.wdata = wdata;
    @(negedge clk);
    cmd_valid = 1'b0;
    if (!resp_valid) begin
      $display("error at %0t: no register response one cycle after the command", $time);
      err_cnt++;
    end
    rdata = resp_data;
  endtask

  task automatic csr_write(input csr_addr_t addr, input vdp_data_t data);
    vdp_data_t rd;
    csr_access(1'b1, addr, data, rd);
    compare("csr_resp_data_o (write)", rd, '0);
  endtask

  task automatic csr_read(input csr_addr_t addr, output vdp_data_t data);
    csr_access(1'b0, addr, '0, data);
  endtask

  task automatic wait_done(input int base);
    int cycles;
    cycles = 0;
    while (done_cnt == base && cycles < run_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (done_cnt == base) begin
      stop_on_timeout("done_o never pulsed");
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  task automatic do_run(input run_row_t row, input logic stall_on, input vdp_data_t expected,
                        output vdp_data_t mem_res);
    vdp_data_t rd;
    int        base;
    @(negedge clk);
    stall <= stall_on;
    u_mem.write_word(row.res_ptr, ~expected);
    csr_write(csr_a_ptr, vdp_data_t'(row.a_ptr));
    csr_write(csr_b_ptr, vdp_data_t'(row.b_ptr));
    csr_write(csr_len, vdp_data_t'(row.len));
    csr_write(csr_res_ptr, vdp_data_t'(row.res_ptr));
    base = done_cnt;
    csr_write(csr_start, 64'd1);
    csr_read(csr_status, rd);
    compare("csr_resp_data_o (status after start)", rd, vdp_data_t'(1) << status_busy_bit);
    // this second start lands while busy and must be dropped.
    csr_write(csr_start, 64'd1);
    wait_done(base);
    repeat (16) @(negedge clk);
    if (done_cnt != base + 1) begin
      $display("error at %0t: done_o pulse count is %0d, expected %0d", $time,
               done_cnt - base, 1);
      err_cnt++;
    end
    csr_read(csr_status, rd);
    compare("csr_resp_data_o (status at end)", rd, vdp_data_t'(1) << status_done_bit);
    csr_read(csr_result, rd);
    compare("csr_resp_data_o (result)", rd, expected);
    mem_res = u_mem.read_word(row.res_ptr);
    compare("memory word at result pointer", mem_res, expected);
  endtask

  initial begin
    csr_addr_t reg_addr [0:3];
    vdp_data_t reg_val [0:3];
    vdp_data_t rd;
    vdp_data_t a_val;
    vdp_data_t b_val;
    vdp_data_t expected;
    vdp_data_t first_res;
    vdp_data_t res;
    int        errs_before;
    int        err_total;
    void'($urandom(32'hea3));
    reset     = 1'b1;
    stall     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    reg_addr  = '{csr_a_ptr, csr_b_ptr, csr_len, csr_res_ptr};
    reg_val   = '{64'h1234_5678, 64'h9abc_def0, 64'h5a, 64'h0bad_f008};
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errs_before = err_cnt;
    csr_read(csr_status, rd);
    compare("csr_resp_data_o (status after reset)", rd, '0);
    for (int i = 0; i < 4; i++) begin
      csr_write(reg_addr[i], reg_val[i]);
      csr_read(reg_addr[i], rd);
      compare($sformatf("csr_resp_data_o (offset %h)", reg_addr[i]), rd, reg_val[i]);
    end
    csr_read(8'h38, rd);
    compare("csr_resp_data_o (unmapped offset)", rd, '0);
    report_test("register access", errs_before);

    for (int r = 0; r < 4; r++) begin
      expected = '0;
      for (int i = 0; i < rows[r].len; i++) begin
        a_val = {$urandom, $urandom};
        b_val = {$urandom, $urandom};
        u_mem.write_word(rows[r].a_ptr + vdp_addr_t'(i * elem_bytes), a_val);
        u_mem.write_word(rows[r].b_ptr + vdp_addr_t'(i * elem_bytes), b_val);
        expected = expected + a_val * b_val;
      end
      errs_before = err_cnt;
      do_run(rows[r], 1'b0, expected, first_res);
      report_test($sformatf("len %0d no stall", rows[r].len), errs_before);
      if (rows[r].stall) begin
        errs_before = err_cnt;
        do_run(rows[r], 1'b1, expected, res);
        compare("memory word under stall", res, first_res);
        report_test($sformatf("len %0d random stall", rows[r].len), errs_before);
      end
    end

    err_total = err_cnt + u_dut.u_checker.fail_cnt;
    $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, u_dut.u_checker.fail_cnt);
    if (err_total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/vdp_pkg.sv
hw/vdp_csr.sv
hw/vdp_fetch.sv
hw/vdp_mul_stage.sv
hw/vdp_accum_stage.sv
hw/vdp_top.sv
tb/vdp_mem_model.sv
tb/vdp_checker.sv
tb/vdp_tb.sv
